/* astro_game.f */
+incdir+common
common/astro_field_pkg.sv
common/astro_control_pkg.sv
source/move_decoder.sv
field/field_motion.sv
field/hit_tracker.sv
source/game_controller.sv
source/astro_game_top.sv
verification/astro_game_tb.sv

/* verification/astro_game_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "astro_macros.svh"

module astro_game_tb
    import astro_field_pkg::*;
    import astro_control_pkg::*;
();

    logic                         clock;
    logic                         clear;
    logic                         start;
    logic                         tick;
    logic                         move_strobe;
    logic [5:0]                   move_code;
    logic [5:0]                   rand_code;
    position_t                    asteroid;
    coord_t                       ship_x;
    game_status_t                 status;
    game_state_t                  state;

    // expected outputs kept in step with the stimulus
    position_t                    exp_ast;
    coord_t                       exp_ship;
    coord_t                       exp_lfsr;
    logic [1:0]                   exp_lives;
    logic [`ASTRO_SCORE_BITS-1:0] exp_score;
    logic                         exp_fast;
    logic                         exp_over;
    game_state_t                  exp_state;
    string                        phase;
    integer                       seed;
    integer                       checks;
    integer                       value_errors;
    integer                       timeouts;
    integer                       i;
    event                         check_now;

    astro_game_top UUT (
        .clock       (clock),
        .clear       (clear),
        .start       (start),
        .tick        (tick),
        .move_strobe (move_strobe),
        .move_code   (move_code),
        .asteroid    (asteroid),
        .ship_x      (ship_x),
        .status      (status),
        .state       (state)
    );

    always #5 clock = ~clock;

    // fibonacci lfsr with taps 4 and 3 feeding bit 0
    function automatic coord_t lfsr_step(input coord_t v);
        logic feedback;
        feedback  = ^(v & 4'b1100);
        lfsr_step = (v << 1) | coord_t'(feedback);
    endfunction

    // move code bits run up, down, right, left, special and shot from the msb
    function automatic coord_t ship_after_move(input coord_t x, input logic [5:0] code);
        ship_after_move = x;
        if (code[2] && !code[3] && x != 4'd0) begin
            ship_after_move = x - 4'd1;
        end else if (code[3] && !code[2] && x != 4'd15) begin
            ship_after_move = x + 4'd1;
        end
    endfunction

    function automatic coord_t row_after_tick(input coord_t y, input logic fast);
        coord_t drop;
        drop = fast ? 4'd2 : 4'd1;
        row_after_tick = (y >= drop) ? y - drop : 4'd0;
    endfunction

    function automatic logic [`ASTRO_SCORE_BITS-1:0] score_after_shot(
        input logic [`ASTRO_SCORE_BITS-1:0] score,
        input logic                         on_target
    );
        score_after_shot = on_target ? score + 1'b1 : score;
    endfunction

    function automatic logic [1:0] lives_after_impact(input logic [1:0] lives);
        lives_after_impact = (lives == 2'd0) ? 2'd0 : lives - 2'd1;
    endfunction

    task automatic report_mismatch(input string name, input logic [15:0] got,
                                   input logic [15:0] want);
        $display("FAILED %s (%s): got %h expected %h", name, phase, got, want);
        value_errors = value_errors + 1;
    endtask

    always @(check_now) begin
        checks = checks + 1;
        if (state !== exp_state) report_mismatch("state", state, exp_state);
        if (asteroid !== exp_ast) report_mismatch("asteroid", asteroid, exp_ast);
        if (ship_x !== exp_ship) report_mismatch("ship_x", ship_x, exp_ship);
        if (status.lives !== exp_lives) report_mismatch("lives", status.lives, exp_lives);
        if (status.score !== exp_score) report_mismatch("score", status.score, exp_score);
        if (status.playing !== (exp_state == st_play))
            report_mismatch("playing", status.playing, exp_state == st_play);
        if (status.game_over !== exp_over)
            report_mismatch("game_over", status.game_over, exp_over);
    end

    // sample half a cycle after the DUT updates
    task automatic check_outputs(input string label);
        phase = label;
        -> check_now;
        @(negedge clock);
    endtask

    task automatic wait_for_state(input game_state_t target, input integer limit);
        integer cycles;
        cycles = 0;
        while (state !== target && cycles < limit) begin
            @(negedge clock);
            cycles = cycles + 1;
        end
        if (state !== target) begin
            $display("timeout while waiting for state %0d after %s", target, phase);
            timeouts = timeouts + 1;
        end
    endtask

    task automatic next_spawn();
        exp_lfsr   = lfsr_step(exp_lfsr);
        exp_ast.x  = exp_lfsr;
        exp_ast.y  = `ASTRO_SPAWN_ROW;
    endtask

    task automatic send_move(input logic [5:0] code);
        @(posedge clock);
        move_strobe <= 1'b1;
        move_code   <= code;
        @(posedge clock);
        move_strobe <= 1'b0;
        move_code   <= 6'd0;
        @(negedge clock);
        @(negedge clock);
        if (exp_state == st_play) begin
            exp_ship = ship_after_move(exp_ship, code);
            exp_fast = exp_fast ^ code[1];
        end
    endtask

    task automatic pulse_tick();
        @(posedge clock);
        tick <= 1'b1;
        @(posedge clock);
        tick <= 1'b0;
        @(negedge clock);
        @(negedge clock);
        if (exp_state == st_play) begin
            exp_ast.y = row_after_tick(exp_ast.y, exp_fast);
        end
    endtask

    task automatic press_start();
        @(posedge clock);
        start <= 1'b1;
        @(posedge clock);
        start <= 1'b0;
        @(negedge clock);
        wait_for_state(st_play, 8);
        exp_lfsr  = `ASTRO_LFSR_SEED;
        next_spawn();
        exp_ship  = 4'd0;
        exp_fast  = 1'b0;
        exp_lives = `ASTRO_START_LIVES;
        exp_score = '0;
        exp_over  = 1'b0;
        exp_state = st_play;
        check_outputs("start");
    endtask

    task automatic steer_to(input coord_t column);
        integer n;
        for (n = 0; n < 16 && exp_ship != column; n = n + 1) begin
            send_move(exp_ship < column ? 6'b001000 : 6'b000100);
            check_outputs("steer");
        end
    endtask

    task automatic fire();
        logic on_target;
        on_target = (exp_ast.x == exp_ship);
        send_move(6'b000001);
        wait_for_state(on_target ? st_destroy : st_resolve_shot, 4);
        wait_for_state(st_play, 8);
        exp_score = score_after_shot(exp_score, on_target);
        if (on_target) begin
            next_spawn();
        end
        check_outputs(on_target ? "hit" : "miss");
    endtask

    task automatic drop_until_impact();
        integer n;
        for (n = 0; n < 16 && exp_ast.y != `ASTRO_SHIP_ROW; n = n + 1) begin
            pulse_tick();
            check_outputs("fall");
        end
        wait_for_state(st_lose_life, 4);
        exp_lives = lives_after_impact(exp_lives);
        if (exp_lives == 2'd0) begin
            exp_over  = 1'b1;
            exp_state = st_game_over;
        end else begin
            next_spawn();
        end
        wait_for_state(exp_state, 8);
        check_outputs("impact");
    endtask

    initial begin
        clock        = 1'b0;
        clear        = 1'b1;
        start        = 1'b0;
        tick         = 1'b0;
        move_strobe  = 1'b0;
        move_code    = 6'd0;
        seed         = 92;
        checks       = 0;
        value_errors = 0;
        timeouts     = 0;
        exp_ast      = '0;
        exp_ship     = 4'd0;
        exp_lfsr     = `ASTRO_LFSR_SEED;
        exp_lives    = 2'd0;
        exp_score    = '0;
        exp_fast     = 1'b0;
        exp_over     = 1'b0;
        exp_state    = st_idle;
        phase        = "reset";
        repeat (16) @(posedge clock);
        clear <= 1'b0;
        @(negedge clock);
        check_outputs("after clear");
        press_start();

        // sweep to both walls with random steps in between
        for (i = 0; i < 17; i = i + 1) begin
            send_move(6'b001000);
            check_outputs("right sweep");
        end
        for (i = 0; i < 40; i = i + 1) begin
            rand_code = $random(seed);
            send_move(rand_code & 6'b111100);
            check_outputs("random move");
        end
        for (i = 0; i < 17; i = i + 1) begin
            send_move(6'b000100);
            check_outputs("left sweep");
        end

        for (i = 0; i < 4; i = i + 1) begin
            pulse_tick();
            check_outputs("normal fall");
        end
        send_move(6'b000010);
        check_outputs("fast on");
        for (i = 0; i < 2; i = i + 1) begin
            pulse_tick();
            check_outputs("fast fall");
        end

        steer_to(exp_ast.x);
        fire();
        fire();

        // fast mode is still on so every drop ends with a step from row 1 to 0
        for (i = 0; i < 3; i = i + 1) begin
            drop_until_impact();
        end
        pulse_tick();
        check_outputs("tick after game over");
        send_move(6'b001011);
        check_outputs("move after game over");

        press_start();
        pulse_tick();
        check_outputs("normal fall after restart");
        steer_to(exp_ast.x);
        fire();

        $display("checks: %0d, value errors: %0d, timeouts: %0d",
                 checks, value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/astro_game_top.sv */
`timescale 1ns/1ps
`default_nettype none

module astro_game_top
    import astro_field_pkg::*;
    import astro_control_pkg::*;
(
    input  wire logic       clock,
    input  wire logic       clear,
    input  wire logic       start,
    input  wire logic       tick,
    input  wire logic       move_strobe,
    input  wire logic [5:0] move_code,
    output position_t       asteroid,
    output coord_t          ship_x,
    output game_status_t    status,
    output game_state_t     state
);

    move_t    actions;
    control_t control;
    logic     hit;
    logic     impact;
    logic     lives_left;

    move_decoder u_decoder (
        .clock       (clock),
        .clear       (clear),
        .move_strobe (move_strobe),
        .move_code   (move_code),
        .actions     (actions)
    );

    // fast mode stays inside the field block, no top-level pin for it
    field_motion u_field (
        .clock     (clock),
        .clear     (clear),
        .actions   (actions),
        .control   (control),
        .asteroid  (asteroid),
        .ship_x    (ship_x),
        .fast_mode ()
    );

    hit_tracker u_tracker (
        .clock      (clock),
        .clear      (clear),
        .control    (control),
        .asteroid   (asteroid),
        .ship_x     (ship_x),
        .hit        (hit),
        .impact     (impact),
        .lives_left (lives_left),
        .status     (status)
    );

    game_controller u_controller (
        .clock      (clock),
        .clear      (clear),
        .start      (start),
        .tick       (tick),
        .actions    (actions),
        .hit        (hit),
        .impact     (impact),
        .lives_left (lives_left),
        .control    (control),
        .state      (state)
    );

endmodule

`default_nettype wire

/* source/game_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module game_controller
    import astro_field_pkg::*;
    import astro_control_pkg::*;
(
    input  wire logic  clock,
    input  wire logic  clear,
    input  wire logic  start,
    input  wire logic  tick,
    input  wire move_t actions,
    input  wire logic  hit,
    input  wire logic  impact,
    input  wire logic  lives_left,
    output control_t   control,
    output game_state_t state
);

    game_state_t state_next;
    logic        fall_q;

    always_ff @(posedge clock or posedge clear) begin
        if (clear) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (start) begin
                    state_next = st_setup;
                end
            end
            st_setup: state_next = st_spawn;
            st_spawn: state_next = st_play;
            st_play: begin
                // a landed asteroid wins over a shot in the same cycle
                if (impact) begin
                    state_next = st_lose_life;
                end else if (actions.shot) begin
                    state_next = st_resolve_shot;
                end
            end
            st_resolve_shot: state_next = hit ? st_destroy : st_play;
            st_destroy: state_next = st_spawn;
            st_lose_life: state_next = st_check_lives;
            st_check_lives: state_next = lives_left ? st_spawn : st_game_over;
            st_game_over: begin
                if (start) begin
                    state_next = st_setup;
                end
            end
            default: state_next = st_idle;
        endcase
    end

    // tick is turned into a one-cycle fall command, only taken in play
    always_ff @(posedge clock or posedge clear) begin
        if (clear) begin
            fall_q <= 1'b0;
        end else begin
            fall_q <= (state == st_play) && tick;
        end
    end

    always_comb begin
        control      = '0;
        control.fall = fall_q;
        case (state)
            st_setup: begin
                control.clear_field = 1'b1;
            end
            st_spawn: begin
                control.spawn           = 1'b1;
                control.respawn_allowed = 1'b1;
            end
            st_play, st_resolve_shot, st_check_lives: begin
                control.respawn_allowed = 1'b1;
            end
            st_destroy: begin
                control.count_hit       = 1'b1;
                control.respawn_allowed = 1'b1;
            end
            st_lose_life: begin
                control.count_loss      = 1'b1;
                control.respawn_allowed = 1'b1;
            end
            default: begin
                control.respawn_allowed = 1'b0;
            end
        endcase
    end

    // play never hands over straight to spawn, so a pending fall cannot meet a spawn
    assert property (@(posedge clock) disable iff (clear)
        !(control.fall && control.spawn))
        else $error("game_controller: fall and spawn in the same cycle");

endmodule

`default_nettype wire

/* field/hit_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "astro_macros.svh"

module hit_tracker
    import astro_field_pkg::*;
    import astro_control_pkg::*;
(
    input  wire logic      clock,
    input  wire logic      clear,
    input  wire control_t  control,
    input  wire position_t asteroid,
    input  wire coord_t    ship_x,
    output logic           hit,
    output logic           impact,
    output logic           lives_left,
    output game_status_t   status
);

    logic [1:0]                   lives;
    logic [`ASTRO_SCORE_BITS-1:0] score;
    logic                         game_over;

    // a shot only needs the column, the ship fires straight up
    assign hit        = (asteroid.x == ship_x);
    assign impact     = (asteroid.y == `ASTRO_SHIP_ROW);
    assign lives_left = (lives != '0);

    always_ff @(posedge clock or posedge clear) begin
        if (clear) begin
            lives     <= '0;
            game_over <= 1'b0;
        end else if (control.clear_field) begin
            lives     <= `ASTRO_START_LIVES;
            game_over <= 1'b0;
        end else if (control.count_loss && lives != '0) begin
            lives <= lives - 2'd1;
            // last life gone
            if (lives == 2'd1) begin
                game_over <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock or posedge clear) begin
        if (clear) begin
            score <= '0;
        end else if (control.clear_field) begin
            score <= '0;
        end else if (control.count_hit) begin
            score <= score + 1'b1;
        end
    end

    always_comb begin
        status.lives     = lives;
        status.score     = score;
        status.playing   = control.respawn_allowed;
        status.game_over = game_over;
    end

    // controller must check lives before asking for another loss
    assert property (@(posedge clock) disable iff (clear)
        control.count_loss |-> lives != '0)
        else $error("hit_tracker: life lost with no lives left");

endmodule

`default_nettype wire

/* field/field_motion.sv */
`timescale 1ns/1ps
`default_nettype none

`include "astro_macros.svh"

module field_motion
    import astro_field_pkg::*;
    import astro_control_pkg::*;
(
    input  wire logic     clock,
    input  wire logic     clear,
    input  wire move_t    actions,
    input  wire control_t control,
    output position_t     asteroid,
    output coord_t        ship_x,
    output logic          fast_mode
);

    logic [`ASTRO_GRID_BITS-1:0] lfsr;
    logic [`ASTRO_GRID_BITS-1:0] lfsr_next;
    coord_t                      fall_step;
    coord_t                      row_next;
    coord_t                      ship_next;

    // saturating add/sub step, used for both the ship and the asteroid
    function automatic coord_t step_coord(
        input coord_t value,
        input coord_t amount,
        input logic   subtract
    );
        logic [`ASTRO_GRID_BITS:0] result;
        if (subtract) begin
            result = {1'b0, value} - {1'b0, amount};
            // borrow out means we went below row or column 0
            step_coord = result[`ASTRO_GRID_BITS] ? coord_t'('0)
                                                  : result[`ASTRO_GRID_BITS-1:0];
        end else begin
            result = {1'b0, value} + {1'b0, amount};
            step_coord = result[`ASTRO_GRID_BITS] ? coord_t'('1)
                                                  : result[`ASTRO_GRID_BITS-1:0];
        end
    endfunction

    // fibonacci lfsr, taps 4 and 3
    assign lfsr_next = {lfsr[2:0], lfsr[3] ^ lfsr[2]};

    assign fall_step = fast_mode ? coord_t'(2) : coord_t'(1);
    assign row_next  = step_coord(asteroid.y, fall_step, 1'b1);
    assign ship_next = step_coord(ship_x, coord_t'(1), actions.left);

    always_ff @(posedge clock or posedge clear) begin
        if (clear) begin
            ship_x    <= '0;
            fast_mode <= 1'b0;
        end else if (control.clear_field) begin
            ship_x    <= '0;
            fast_mode <= 1'b0;
        end else if (control.respawn_allowed) begin
            if (actions.left || actions.right) begin
                ship_x <= ship_next;
            end
            if (actions.special) begin
                fast_mode <= !fast_mode;
            end
        end
    end

    always_ff @(posedge clock or posedge clear) begin
        if (clear) begin
            asteroid <= '0;
            lfsr     <= `ASTRO_LFSR_SEED;
        end else if (control.clear_field) begin
            asteroid <= '0;
            lfsr     <= `ASTRO_LFSR_SEED;
        end else if (control.spawn) begin
            // new asteroid takes the next column in the sequence
            lfsr       <= lfsr_next;
            asteroid.x <= lfsr_next;
            asteroid.y <= `ASTRO_SPAWN_ROW;
        end else if (control.fall) begin
            asteroid.y <= row_next;
        end
    end

    // an all-zero lfsr would lock every spawn into column 0
    assert property (@(posedge clock) disable iff (clear) lfsr != '0)
        else $error("field_motion: spawn lfsr reached zero");

endmodule

`default_nettype wire

/* source/move_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module move_decoder
    import astro_field_pkg::*;
(
    input  wire logic       clock,
    input  wire logic       clear,
    input  wire logic       move_strobe,
    input  wire logic [5:0] move_code,
    output move_t           actions
);

    move_t decoded;

    // left and right in the same code cancel each other
    always_comb begin
        decoded = move_t'(move_code);
        if (decoded.left && decoded.right) begin
            decoded.left  = 1'b0;
            decoded.right = 1'b0;
        end
    end

    // without a strobe the register drops back to zero so each action is a single pulse
    always_ff @(posedge clock or posedge clear) begin
        if (clear) begin
            actions <= '0;
        end else if (move_strobe) begin
            actions <= decoded;
        end else begin
            actions <= '0;
        end
    end

endmodule

`default_nettype wire

/* common/astro_control_pkg.sv */
`default_nettype none

`include "astro_macros.svh"

package astro_control_pkg;

    typedef enum logic [3:0] {
        st_idle         = 4'd0,
        st_setup        = 4'd1,
        st_spawn        = 4'd2,
        st_play         = 4'd3,
        st_resolve_shot = 4'd4,
        st_destroy      = 4'd5,
        st_lose_life    = 4'd6,
        st_check_lives  = 4'd7,
        st_game_over    = 4'd8
    } game_state_t;

    // datapath commands from the game controller
    typedef struct packed {
        logic clear_field;
        logic spawn;
        logic fall;
        // game in progress, ship moves and spawns are accepted
        logic respawn_allowed;
        logic count_loss;
        logic count_hit;
    } control_t;

    typedef struct packed {
        logic [1:0]                   lives;
        logic [`ASTRO_SCORE_BITS-1:0] score;
        logic                         playing;
        logic                         game_over;
    } game_status_t;

endpackage

`default_nettype wire

/* common/astro_field_pkg.sv */
`default_nettype none

`include "astro_macros.svh"

package astro_field_pkg;

    // one grid coordinate, row or column
    typedef logic [`ASTRO_GRID_BITS-1:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } position_t;

    // same bit order as the raw move code, up is the msb
    typedef struct packed {
        logic up;
        logic down;
        logic right;
        logic left;
        logic special;
        logic shot;
    } move_t;

endpackage

`default_nettype wire

/* common/astro_macros.svh */
`ifndef ASTRO_MACROS_SVH
`define ASTRO_MACROS_SVH

// 16 by 16 grid, one nibble per coordinate
`define ASTRO_GRID_BITS   4

// ship lives on the bottom row, asteroids enter at the top
`define ASTRO_SHIP_ROW    4'd0
`define ASTRO_SPAWN_ROW   4'd15

`define ASTRO_START_LIVES 2'd3
`define ASTRO_SCORE_BITS  8

// spawn LFSR start value, must be nonzero
`define ASTRO_LFSR_SEED   4'h9

`endif
